/* src/i3c_ddr_pkg.sv */
`default_nettype none

package i3c_ddr_pkg;

	// register file address width
	localparam int REGF_AW = 12;

	// target address = device index + base
	localparam logic [6:0] DEV_BASE_ADDR = 7'd8;

	// one state per protocol step of a private transfer
	typedef enum logic [4:0] {
		ST_IDLE        = 5'd0,
		ST_CMD_PRE     = 5'd1,  // command preamble, 01
		ST_SEVEN_ZEROS = 5'd2,
		ST_ADDRESS     = 5'd3,
		ST_PARITY      = 5'd4,  // command or data parity, see data parity flag
		ST_ACK_PRE     = 5'd5,  // first preamble bit, driven by controller
		ST_ACK_WAIT    = 5'd6,  // second preamble bit, ack/nack from target
		ST_FIRST_BYTE  = 5'd7,
		ST_SECOND_BYTE = 5'd8,
		ST_DATA_PRE    = 5'd9,  // preamble in front of the next data word
		ST_CRC_PRE1    = 5'd11,
		ST_CRC_PRE2    = 5'd12,
		ST_TOKEN       = 5'd13, // 4 bit crc token
		ST_CRC_VALUE   = 5'd14, // 5 bit crc
		ST_ERROR       = 5'd15,
		ST_RESTART     = 5'd16,
		ST_EXIT        = 5'd17,
		ST_RW_BIT      = 5'd18,
		ST_PAD_BYTE    = 5'd19  // dummy byte for odd byte count
	} ddr_state_t;

	// serializer modes
	typedef enum logic [3:0] {
		TX_SPECIAL_PRE = 4'd0,
		TX_ADDRESS     = 4'd1,
		TX_ONE_PRE     = 4'd2,
		TX_SEVEN_ZEROS = 4'd3,
		TX_PARITY      = 4'd4,
		TX_ZERO_PRE    = 4'd6,
		TX_BYTE        = 4'd7,
		TX_TOKEN_CRC   = 4'd12,
		TX_CRC_VALUE   = 4'd13,
		TX_EXIT        = 4'd14,
		TX_RESTART     = 4'd15
	} tx_mode_t;

	// deserializer modes
	typedef enum logic [2:0] {
		RX_PREAMBLE     = 3'd0,
		RX_CRC_CHECK    = 3'd2,
		RX_BYTE         = 3'd3,
		RX_ERROR        = 3'd4,
		RX_PARITY_CHECK = 3'd6,
		RX_TOKEN_CHECK  = 3'd7
	} rx_mode_t;

	// error codes reported to the register file
	typedef enum logic [3:0] {
		ERR_SUCCESS    = 4'd0,
		ERR_CRC        = 4'd1,
		ERR_PARITY     = 4'd2,
		ERR_FRAME      = 4'd3,
		ERR_NACK       = 4'd5,
		ERR_SHORT_READ = 4'd7
	} err_type_t;

endpackage

`default_nettype wire

/* src/ddr_frame_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr_frame_seq (
	input  wire                     i_sys_clk,
	input  wire                     i_sys_rst,
	input  wire                     i_engine_en,
	input  wire                     i_tx_mode_done,
	input  wire                     i_rx_mode_done,
	input  wire                     i_rx_pre,
	input  wire                     i_rx_error,
	input  wire                     i_frmcnt_last,
	input  wire                     i_regf_wr_rd_bit,   // 0 write, 1 read
	input  wire                     i_regf_short_read,  // 1 short read is an error
	input  wire                     i_regf_toc,         // 0 restart, 1 exit
	output i3c_ddr_pkg::ddr_state_t o_state,
	output logic                    o_data_parity       // parity in progress covers data
);
	import i3c_ddr_pkg::*;

	ddr_state_t next_state;
	ddr_state_t end_state;  // where a finished or failed frame goes
	logic       any_done;   // tx or rx side finished its mode

	assign any_done  = i_tx_mode_done | i_rx_mode_done;
	assign end_state = i_regf_toc ? ST_EXIT : ST_RESTART;

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
			o_state <= ST_IDLE;
		else
			o_state <= next_state;
	end

	// command parity follows the address, data parity follows a byte pair
	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
			o_data_parity <= 1'b0;
		else if (o_state == ST_ADDRESS)
			o_data_parity <= 1'b0;
		else if (o_state == ST_SECOND_BYTE || o_state == ST_PAD_BYTE)
			o_data_parity <= 1'b1;
	end

	always_comb
	begin
		next_state = o_state;  // hold until the mode in progress reports done
		case (o_state)
			ST_IDLE:
				if (i_engine_en)
					next_state = ST_CMD_PRE;
			ST_CMD_PRE:
				if (i_tx_mode_done)
					next_state = ST_RW_BIT;
			ST_RW_BIT:
				if (i_tx_mode_done)
					next_state = ST_SEVEN_ZEROS;
			ST_SEVEN_ZEROS:
				if (i_tx_mode_done)
					next_state = ST_ADDRESS;
			ST_ADDRESS:
				if (i_tx_mode_done)
					next_state = ST_PARITY;
			ST_PARITY:
				if (any_done)
				begin
					if (!o_data_parity)
						next_state = ST_ACK_PRE;  // command done, ask for ack
					else if (i_regf_wr_rd_bit && i_rx_error)
						next_state = ST_ERROR;    // bad data parity on read
					else if (i_frmcnt_last)
						next_state = ST_CRC_PRE1;
					else
						next_state = ST_DATA_PRE;
				end
			ST_ACK_PRE:
				if (i_tx_mode_done)
					next_state = ST_ACK_WAIT;
			ST_ACK_WAIT:
				if (i_rx_mode_done)
				begin
					if (!i_rx_pre)
						next_state = ST_FIRST_BYTE;  // ack is a low bit
					else
						next_state = ST_ERROR;       // nack
				end
			ST_FIRST_BYTE:
				if (any_done)
				begin
					if (i_frmcnt_last)
						next_state = ST_PAD_BYTE;  // odd count, pad the word
					else
						next_state = ST_SECOND_BYTE;
				end
			ST_SECOND_BYTE:
				if (any_done)
					next_state = ST_PARITY;
			ST_PAD_BYTE:
				if (any_done)
					next_state = ST_PARITY;
			ST_DATA_PRE:
				if (any_done)
				begin
					if (!i_regf_wr_rd_bit || i_rx_pre)
						next_state = ST_FIRST_BYTE;  // another word follows
					else if (!i_frmcnt_last && i_regf_short_read)
						next_state = ST_ERROR;       // target ended early
					else
						next_state = ST_CRC_PRE2;    // target ended, crc follows
				end
			ST_CRC_PRE1:
				if (any_done)
					next_state = ST_CRC_PRE2;
			ST_CRC_PRE2:
				if (any_done)
				begin
					if (i_regf_wr_rd_bit && !i_rx_pre)
						next_state = ST_ERROR;  // preamble 00 is a framing error
					else
						next_state = ST_TOKEN;
				end
			ST_TOKEN:
				if (any_done)
				begin
					if (i_regf_wr_rd_bit && i_rx_error)
						next_state = ST_ERROR;
					else
						next_state = ST_CRC_VALUE;
				end
			ST_CRC_VALUE:
				if (any_done)
				begin
					if (i_regf_wr_rd_bit && i_rx_error)
						next_state = ST_ERROR;
					else
						next_state = end_state;
				end
			ST_ERROR:
				if (i_rx_mode_done)
					next_state = end_state;  // deserializer drained the bus
			ST_RESTART,
			ST_EXIT:
				if (i_tx_mode_done)
					next_state = ST_IDLE;
			default:
				next_state = ST_IDLE;
		endcase
	end

	// a frame only starts on request
	a_idle_needs_en: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		(o_state == ST_IDLE && !i_engine_en) |=> (o_state == ST_IDLE));

endmodule

`default_nettype wire

/* src/ddr_lane_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr_lane_ctrl #(
	parameter logic [4:0] RESTART_STALL = 5'd10,
	parameter logic [4:0] EXIT_STALL    = 5'd16
) (
	input  wire i3c_ddr_pkg::ddr_state_t i_state,
	input  wire                     i_data_parity,
	input  wire                     i_regf_wr_rd_bit,
	input  wire  [4:0]              i_regf_dev_index,
	input  wire                     i_regf_toc,
	input  wire                     i_regf_short_read,
	input  wire                     i_frmcnt_last,
	input  wire                     i_rx_pre,
	input  wire                     i_rx_error,
	input  wire                     i_rx_mode_done,
	input  wire                     i_tx_mode_done,
	output logic                    o_tx_en,
	output i3c_ddr_pkg::tx_mode_t   o_tx_mode,
	output logic                    o_rx_en,
	output i3c_ddr_pkg::rx_mode_t   o_rx_mode,
	output logic [7:0]              o_tx_special_data,
	output i3c_ddr_pkg::err_type_t  o_regf_error_type,
	output logic                    o_sclstall_en,
	output logic [4:0]              o_sclstall_no_of_cycles,
	output logic                    o_engine_done
);
	import i3c_ddr_pkg::*;

	logic [6:0] target_addr;
	logic [4:0] end_stall;  // stall length of the pattern that ends this frame

	assign target_addr = {2'b00, i_regf_dev_index} + DEV_BASE_ADDR;
	assign end_stall   = i_regf_toc ? EXIT_STALL : RESTART_STALL;

	always_comb
	begin
		o_tx_en                 = 1'b0;
		o_tx_mode               = TX_SPECIAL_PRE;
		o_rx_en                 = 1'b0;
		o_rx_mode               = RX_PREAMBLE;
		o_tx_special_data       = 8'd0;
		o_regf_error_type       = ERR_SUCCESS;
		o_sclstall_en           = 1'b0;
		o_sclstall_no_of_cycles = 5'd0;
		o_engine_done           = 1'b0;
		case (i_state)
			ST_CMD_PRE:
			begin
				o_tx_en   = 1'b1;
				o_tx_mode = TX_SPECIAL_PRE;
			end
			ST_RW_BIT:
			begin
				o_tx_en   = 1'b1;
				o_tx_mode = i_regf_wr_rd_bit ? TX_ONE_PRE : TX_ZERO_PRE;
			end
			ST_SEVEN_ZEROS:
			begin
				o_tx_en   = 1'b1;
				o_tx_mode = TX_SEVEN_ZEROS;
			end
			ST_ADDRESS:
			begin
				o_tx_en           = 1'b1;
				o_tx_mode         = TX_ADDRESS;
				o_tx_special_data = {1'b0, target_addr};  // serializer adds parity adjust
			end
			ST_PARITY:
			begin
				if (i_regf_wr_rd_bit && i_data_parity)
				begin
					o_rx_en   = 1'b1;
					o_rx_mode = RX_PARITY_CHECK;  // target's data parity
					if (i_rx_mode_done && i_rx_error)
						o_regf_error_type = ERR_PARITY;
				end
				else
				begin
					o_tx_en   = 1'b1;
					o_tx_mode = TX_PARITY;  // command parity, or write data parity
				end
			end
			ST_ACK_PRE:
			begin
				o_tx_en   = 1'b1;
				o_tx_mode = TX_ONE_PRE;
			end
			ST_ACK_WAIT:
			begin
				o_rx_en   = 1'b1;
				o_rx_mode = RX_PREAMBLE;
				if (i_rx_mode_done && i_rx_pre)
					o_regf_error_type = ERR_NACK;  // nobody pulled sda low
			end
			ST_FIRST_BYTE,
			ST_SECOND_BYTE,
			ST_PAD_BYTE:
			begin
				o_tx_en   = !i_regf_wr_rd_bit;
				o_tx_mode = TX_BYTE;
				o_rx_en   = i_regf_wr_rd_bit;
				o_rx_mode = RX_BYTE;
			end
			ST_DATA_PRE:
			begin
				if (i_regf_wr_rd_bit)
				begin
					o_rx_en   = 1'b1;
					o_rx_mode = RX_PREAMBLE;  // target says more data or done
					if (i_rx_mode_done && !i_rx_pre && !i_frmcnt_last && i_regf_short_read)
						o_regf_error_type = ERR_SHORT_READ;
				end
				else
				begin
					o_tx_en   = 1'b1;
					o_tx_mode = TX_ONE_PRE;
				end
			end
			ST_CRC_PRE1:
			begin
				o_tx_en   = 1'b1;
				o_tx_mode = TX_ZERO_PRE;
			end
			ST_CRC_PRE2:
			begin
				if (i_regf_wr_rd_bit)
				begin
					o_rx_en   = 1'b1;
					o_rx_mode = RX_PREAMBLE;
					if (i_rx_mode_done && !i_rx_pre)
						o_regf_error_type = ERR_FRAME;
				end
				else
				begin
					o_tx_en   = 1'b1;
					o_tx_mode = TX_ONE_PRE;
				end
			end
			ST_TOKEN:
			begin
				o_tx_en   = !i_regf_wr_rd_bit;
				o_tx_mode = TX_TOKEN_CRC;
				o_rx_en   = i_regf_wr_rd_bit;
				o_rx_mode = RX_TOKEN_CHECK;
				if (i_regf_wr_rd_bit && i_rx_mode_done && i_rx_error)
					o_regf_error_type = ERR_FRAME;  // wrong token
			end
			ST_CRC_VALUE:
			begin
				o_tx_en                 = !i_regf_wr_rd_bit;
				o_tx_mode               = TX_CRC_VALUE;
				o_rx_en                 = i_regf_wr_rd_bit;
				o_rx_mode               = RX_CRC_CHECK;
				o_sclstall_no_of_cycles = end_stall;  // preset for the staller
				if (i_regf_wr_rd_bit && i_rx_mode_done && i_rx_error)
					o_regf_error_type = ERR_CRC;
			end
			ST_ERROR:
			begin
				o_rx_en                 = 1'b1;
				o_rx_mode               = RX_ERROR;
				o_sclstall_no_of_cycles = end_stall;
			end
			ST_RESTART:
			begin
				o_tx_en                 = 1'b1;
				o_tx_mode               = TX_RESTART;
				o_sclstall_no_of_cycles = RESTART_STALL;
				o_sclstall_en           = !i_tx_mode_done;  // release with the pattern done
			end
			ST_EXIT:
			begin
				o_tx_en                 = 1'b1;
				o_tx_mode               = TX_EXIT;
				o_sclstall_no_of_cycles = EXIT_STALL;
				o_sclstall_en           = !i_tx_mode_done;
				o_engine_done           = i_tx_mode_done;
			end
			default:
			begin
				o_tx_en = 1'b0;  // idle, lane released
			end
		endcase
	end

	// only one side may own sda in any state
	a_lane_excl: assert final (!(o_tx_en && o_rx_en));

endmodule

`default_nettype wire

/* src/ddr_regf_ptr.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr_regf_ptr #(
	parameter logic [i3c_ddr_pkg::REGF_AW-1:0] WR_START_ADDR = 'd1,
	parameter logic [i3c_ddr_pkg::REGF_AW-1:0] RD_START_ADDR = 'd10,
	parameter logic [i3c_ddr_pkg::REGF_AW-1:0] PAD_ADDR      = 'd999
) (
	input  wire                                i_sys_clk,
	input  wire                                i_sys_rst,
	input  wire i3c_ddr_pkg::ddr_state_t       i_state,
	input  wire                                i_regf_wr_rd_bit,
	input  wire                                i_tx_mode_done,
	input  wire                                i_rx_mode_done,
	input  wire                                i_rx_pre,
	input  wire                                i_frmcnt_last,
	output logic [i3c_ddr_pkg::REGF_AW-1:0]    o_regf_addr,
	output logic                               o_regf_rd_en,
	output logic                               o_regf_wr_en
);
	import i3c_ddr_pkg::*;

	logic byte_done;  // current data byte finished on the active lane
	logic data_byte;  // state carries a real data byte

	assign byte_done = i_regf_wr_rd_bit ? i_rx_mode_done : i_tx_mode_done;
	assign data_byte = (i_state == ST_FIRST_BYTE) || (i_state == ST_SECOND_BYTE);

	// write transfer reads the regfile, read transfer writes it
	assign o_regf_rd_en = !i_regf_wr_rd_bit && (data_byte || i_state == ST_PAD_BYTE);
	assign o_regf_wr_en = i_regf_wr_rd_bit && data_byte;  // pad from target is dropped

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
			o_regf_addr <= '0;
		else
		begin
			case (i_state)
				ST_ACK_WAIT:
					if (i_rx_mode_done && !i_rx_pre)  // ack, load start for direction
						o_regf_addr <= i_regf_wr_rd_bit ? RD_START_ADDR : WR_START_ADDR;
				ST_FIRST_BYTE:
					if (byte_done)
					begin
						if (i_frmcnt_last)
							o_regf_addr <= PAD_ADDR;  // odd count, pad byte comes next
						else
							o_regf_addr <= o_regf_addr + 1'b1;
					end
				ST_SECOND_BYTE:
					if (byte_done)
						o_regf_addr <= o_regf_addr + 1'b1;
				default:
					o_regf_addr <= o_regf_addr;
			endcase
		end
	end

	a_strobe_excl: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		!(o_regf_rd_en && o_regf_wr_en));

	// the pointer must already sit on the pad slot when the sequencer enters the pad byte
	a_pad_addr: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		(i_state == ST_PAD_BYTE) |-> (o_regf_addr == PAD_ADDR));

endmodule

`default_nettype wire

/* src/ddr_engine_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr_engine_top #(
	parameter logic [i3c_ddr_pkg::REGF_AW-1:0] WR_START_ADDR = 'd1,
	parameter logic [i3c_ddr_pkg::REGF_AW-1:0] RD_START_ADDR = 'd10,
	parameter logic [i3c_ddr_pkg::REGF_AW-1:0] PAD_ADDR      = 'd999,
	parameter logic [4:0]                      RESTART_STALL = 5'd10,
	parameter logic [4:0]                      EXIT_STALL    = 5'd16
) (
	input  wire                             i_sys_clk,
	input  wire                             i_sys_rst,
	input  wire                             i_engine_en,
	input  wire                             i_tx_mode_done,
	input  wire                             i_rx_mode_done,
	input  wire                             i_rx_pre,
	input  wire                             i_rx_error,
	input  wire                             i_frmcnt_last,
	input  wire                             i_regf_toc,
	input  wire  [4:0]                      i_regf_dev_index,
	input  wire                             i_regf_short_read,
	input  wire                             i_regf_wr_rd_bit,
	output wire                             o_tx_en,
	output i3c_ddr_pkg::tx_mode_t           o_tx_mode,
	output wire                             o_rx_en,
	output i3c_ddr_pkg::rx_mode_t           o_rx_mode,
	output wire  [7:0]                      o_tx_special_data,
	output i3c_ddr_pkg::err_type_t          o_regf_error_type,
	output wire                             o_sclstall_en,
	output wire  [4:0]                      o_sclstall_no_of_cycles,
	output wire                             o_engine_done,
	output wire  [i3c_ddr_pkg::REGF_AW-1:0] o_regf_addr,
	output wire                             o_regf_rd_en,
	output wire                             o_regf_wr_en
);
	import i3c_ddr_pkg::*;

	ddr_state_t state;        // sequencer state, shared by decode and pointer
	logic       data_parity;  // parity step covers data

	ddr_frame_seq u_seq (
		.i_sys_clk         (i_sys_clk),
		.i_sys_rst         (i_sys_rst),
		.i_engine_en       (i_engine_en),
		.i_tx_mode_done    (i_tx_mode_done),
		.i_rx_mode_done    (i_rx_mode_done),
		.i_rx_pre          (i_rx_pre),
		.i_rx_error        (i_rx_error),
		.i_frmcnt_last     (i_frmcnt_last),
		.i_regf_wr_rd_bit  (i_regf_wr_rd_bit),
		.i_regf_short_read (i_regf_short_read),
		.i_regf_toc        (i_regf_toc),
		.o_state           (state),
		.o_data_parity     (data_parity)
	);

	ddr_lane_ctrl #(
		.RESTART_STALL (RESTART_STALL),
		.EXIT_STALL    (EXIT_STALL)
	) u_lane (
		.i_state                 (state),
		.i_data_parity           (data_parity),
		.i_regf_wr_rd_bit        (i_regf_wr_rd_bit),
		.i_regf_dev_index        (i_regf_dev_index),
		.i_regf_toc              (i_regf_toc),
		.i_regf_short_read       (i_regf_short_read),
		.i_frmcnt_last           (i_frmcnt_last),
		.i_rx_pre                (i_rx_pre),
		.i_rx_error              (i_rx_error),
		.i_rx_mode_done          (i_rx_mode_done),
		.i_tx_mode_done          (i_tx_mode_done),
		.o_tx_en                 (o_tx_en),
		.o_tx_mode               (o_tx_mode),
		.o_rx_en                 (o_rx_en),
		.o_rx_mode               (o_rx_mode),
		.o_tx_special_data       (o_tx_special_data),
		.o_regf_error_type       (o_regf_error_type),
		.o_sclstall_en           (o_sclstall_en),
		.o_sclstall_no_of_cycles (o_sclstall_no_of_cycles),
		.o_engine_done           (o_engine_done)
	);

	ddr_regf_ptr #(
		.WR_START_ADDR (WR_START_ADDR),
		.RD_START_ADDR (RD_START_ADDR),
		.PAD_ADDR      (PAD_ADDR)
	) u_ptr (
		.i_sys_clk        (i_sys_clk),
		.i_sys_rst        (i_sys_rst),
		.i_state          (state),
		.i_regf_wr_rd_bit (i_regf_wr_rd_bit),
		.i_tx_mode_done   (i_tx_mode_done),
		.i_rx_mode_done   (i_rx_mode_done),
		.i_rx_pre         (i_rx_pre),
		.i_frmcnt_last    (i_frmcnt_last),
		.o_regf_addr      (o_regf_addr),
		.o_regf_rd_en     (o_regf_rd_en),
		.o_regf_wr_en     (o_regf_wr_en)
	);

endmodule

`default_nettype wire

/* sim/ddr_bus_model.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr_bus_model (
	input  wire                    i_sys_clk,
	input  wire                    i_sys_rst,
	input  wire                    i_tx_en,
	input  wire i3c_ddr_pkg::tx_mode_t i_tx_mode,
	input  wire                    i_rx_en,
	input  wire i3c_ddr_pkg::rx_mode_t i_rx_mode,
	input  wire  [7:0]             i_nbytes,     // data bytes in this frame
	input  wire                    i_nack,       // target refuses the command
	input  wire                    i_short_end,  // target stops after the first pair
	input  wire                    i_crc_err,    // crc check fails on a read
	output logic                   o_tx_mode_done,
	output logic                   o_rx_mode_done,
	output logic                   o_rx_pre,
	output logic                   o_rx_error,
	output logic                   o_frmcnt_last,
	output logic                   o_ack_seen    // ack slot of this frame is over
);
	import i3c_ddr_pkg::*;

	logic [7:0] lfsr;
	logic [1:0] delay;
	logic [1:0] wait_cnt;
	logic       busy;       // a mode is being served
	logic [7:0] byte_cnt;   // bytes finished in this frame, pad included
	logic       byte_mode;
	integer     k;

	// galois lfsr, x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
	endfunction

	assign byte_mode = (i_tx_en && i_tx_mode == TX_BYTE) || (i_rx_en && i_rx_mode == RX_BYTE);

	always @(negedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
		begin
			lfsr = 8'd67;
			delay = 2'd0;
			wait_cnt <= 2'd0;
			busy <= 1'b0;
			byte_cnt <= 8'd0;
			o_tx_mode_done <= 1'b0;
			o_rx_mode_done <= 1'b0;
			o_rx_pre <= 1'b0;
			o_rx_error <= 1'b0;
			o_frmcnt_last <= 1'b0;
			o_ack_seen <= 1'b0;
		end
		else
		begin
			o_tx_mode_done <= 1'b0;  // done is a single cycle
			o_rx_mode_done <= 1'b0;
			o_rx_error <= 1'b0;
			// in a byte: is this the last byte, elsewhere: are all bytes through
			o_frmcnt_last <= byte_mode ? (byte_cnt + 8'd1 == i_nbytes) : (byte_cnt >= i_nbytes);
			if (o_tx_mode_done || o_rx_mode_done)
			begin
				if (o_rx_mode_done)
					o_ack_seen <= 1'b1;  // first target answer is always the ack slot
			end
			else if (!busy)
			begin
				if (i_tx_en && i_tx_mode == TX_SPECIAL_PRE)
				begin
					byte_cnt <= 8'd0;  // new frame
					o_ack_seen <= 1'b0;
				end
				if (i_tx_en || i_rx_en)
				begin
					for (k = 0; k < 2; k = k + 1)
					begin
						delay = {delay[0], lfsr[0]};  // one step per bit
						lfsr = lfsr_next(lfsr);
					end
					wait_cnt <= delay;
					busy <= 1'b1;
				end
			end
			else if (wait_cnt != 2'd0)
				wait_cnt <= wait_cnt - 2'd1;
			else
			begin
				busy <= 1'b0;
				if (byte_mode)
					byte_cnt <= byte_cnt + 8'd1;
				if (i_tx_en)
					o_tx_mode_done <= 1'b1;
				else
				begin
					o_rx_mode_done <= 1'b1;
					if (i_rx_mode == RX_PREAMBLE)
						o_rx_pre <= o_ack_seen ? !i_short_end : i_nack;  // high is nack or more data
					o_rx_error <= (i_rx_mode == RX_CRC_CHECK) && i_crc_err;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* sim/tb_ddr_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ddr_engine;
	import i3c_ddr_pkg::*;

	localparam logic [REGF_AW-1:0] WR_START = 12'd1;
	localparam logic [REGF_AW-1:0] RD_START = 12'd10;
	localparam logic [REGF_AW-1:0] PAD      = 12'd999;
	localparam logic [4:0] RESTART_CYC = 5'd10;
	localparam logic [4:0] EXIT_CYC    = 5'd16;
	localparam int N_TESTS        = 6;
	localparam int MAX_STEPS      = 50;  // protocol steps per frame, generous
	localparam int STEP_CYCLES    = 8;   // worst step of the bus model plus slack
	localparam int TIMEOUT_CYCLES = N_TESTS * MAX_STEPS * STEP_CYCLES + 600;

	logic i_sys_clk, i_sys_rst, i_engine_en;
	logic i_regf_toc, i_regf_short_read, i_regf_wr_rd_bit;
	logic [4:0] i_regf_dev_index;
	logic i_tx_mode_done, i_rx_mode_done, i_rx_pre, i_rx_error, i_frmcnt_last;
	logic ack_seen;
	logic o_tx_en, o_rx_en, o_sclstall_en, o_engine_done, o_regf_rd_en, o_regf_wr_en;
	tx_mode_t o_tx_mode;
	rx_mode_t o_rx_mode;
	err_type_t o_regf_error_type;
	logic [7:0] o_tx_special_data;
	logic [4:0] o_sclstall_no_of_cycles;
	logic [REGF_AW-1:0] o_regf_addr;
	logic [7:0] nbytes;
	logic nack, short_end, crc_err, started, clr_cnt;
	int err_cnt, pass_tests, fail_tests;
	int strobe_cnt, done_cnt, frame_ends, cycle_cnt;

	ddr_engine_top #(
		.WR_START_ADDR (WR_START),
		.RD_START_ADDR (RD_START),
		.PAD_ADDR      (PAD),
		.RESTART_STALL (RESTART_CYC),
		.EXIT_STALL    (EXIT_CYC)
	) u_dut (.*);

	ddr_bus_model u_bus (
		.i_sys_clk      (i_sys_clk),
		.i_sys_rst      (i_sys_rst),
		.i_tx_en        (o_tx_en),
		.i_tx_mode      (o_tx_mode),
		.i_rx_en        (o_rx_en),
		.i_rx_mode      (o_rx_mode),
		.i_nbytes       (nbytes),
		.i_nack         (nack),
		.i_short_end    (short_end),
		.i_crc_err      (crc_err),
		.o_tx_mode_done (i_tx_mode_done),
		.o_rx_mode_done (i_rx_mode_done),
		.o_rx_pre       (i_rx_pre),
		.o_rx_error     (i_rx_error),
		.o_frmcnt_last  (i_frmcnt_last),
		.o_ack_seen     (ack_seen)
	);

	// data bytes walk up from the start slot, then the pad slot
	function automatic logic [REGF_AW-1:0] exp_regf_addr(input int idx, input logic rd,
		input int n);
		exp_regf_addr = (idx < n) ? ((rd ? RD_START : WR_START) + idx[REGF_AW-1:0]) : PAD;
	endfunction

	// index plus base stays below 128, so the byte's top bit is 0
	function automatic logic [7:0] target_byte(input logic [4:0] dev);
		target_byte = {3'b000, dev} + {1'b0, DEV_BASE_ADDR};
	endfunction

	// count one failed check and show it
	task automatic report_error(input string msg);
		begin
			err_cnt++;
			$display("%s", msg);
		end
	endtask

	initial
	begin
		i_sys_clk = 1'b0;
		forever #4 i_sys_clk = ~i_sys_clk;
	end

	always @(posedge i_sys_clk)
	begin
		if (clr_cnt)
		begin
			strobe_cnt <= 0;
			done_cnt <= 0;
			frame_ends <= 0;
		end
		else
		begin
			if ((o_regf_rd_en && i_tx_mode_done) || (o_regf_wr_en && i_rx_mode_done))
				strobe_cnt <= strobe_cnt + 1;  // byte finished on a strobe
			if (o_engine_done)
				done_cnt <= done_cnt + 1;
			if (o_tx_en && (o_tx_mode == TX_RESTART || o_tx_mode == TX_EXIT) && i_tx_mode_done)
				frame_ends <= frame_ends + 1;
		end
	end

	always @(posedge i_sys_clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles, the frame never reached its end", cycle_cnt);
			$display("Regression failed");
			$finish;
		end
	end

	a_quiet: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		!started |-> !(o_tx_en || o_rx_en || o_regf_rd_en || o_regf_wr_en ||
		o_sclstall_en || o_engine_done))
		else report_error($sformatf(
			"CHECK FAILED idle {tx_en,rx_en,rd_en,wr_en,sclstall_en,engine_done} %h",
			$sampled({o_tx_en, o_rx_en, o_regf_rd_en, o_regf_wr_en,
			o_sclstall_en, o_engine_done})));
	a_start: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		$rose(i_engine_en) |=> (o_tx_en && o_tx_mode == TX_SPECIAL_PRE))
		else report_error($sformatf("CHECK FAILED o_tx_mode got %h expected %h, o_tx_en %h",
			$sampled(o_tx_mode), TX_SPECIAL_PRE, $sampled(o_tx_en)));
	a_rw_bit: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		(o_tx_en && o_tx_mode == TX_SPECIAL_PRE && i_tx_mode_done) |=>
		(o_tx_en && o_tx_mode == (i_regf_wr_rd_bit ? TX_ONE_PRE : TX_ZERO_PRE)))
		else report_error($sformatf("CHECK FAILED o_tx_mode for rw bit got %h, rw %h",
			$sampled(o_tx_mode), $sampled(i_regf_wr_rd_bit)));
	a_target: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		(o_tx_en && o_tx_mode == TX_ADDRESS) |->
		o_tx_special_data == target_byte(i_regf_dev_index))
		else report_error($sformatf("CHECK FAILED o_tx_special_data got %h expected %h",
			$sampled(o_tx_special_data), target_byte($sampled(i_regf_dev_index))));
	a_strobe_addr: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		((o_regf_rd_en && i_tx_mode_done) || (o_regf_wr_en && i_rx_mode_done)) |->
		(o_regf_addr == exp_regf_addr(strobe_cnt, i_regf_wr_rd_bit, nbytes) &&
		o_regf_rd_en == !i_regf_wr_rd_bit))
		else report_error($sformatf("CHECK FAILED o_regf_addr got %h expected %h, rd_en %h",
			$sampled(o_regf_addr),
			exp_regf_addr($sampled(strobe_cnt), $sampled(i_regf_wr_rd_bit), nbytes),
			$sampled(o_regf_rd_en)));
	a_nack: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		(!ack_seen && o_rx_en && o_rx_mode == RX_PREAMBLE && i_rx_mode_done && i_rx_pre) |->
		(o_regf_error_type == ERR_NACK) ##1 (o_rx_en && o_rx_mode == RX_ERROR))
		else report_error($sformatf("CHECK FAILED nack o_regf_error_type %h o_rx_mode %h",
			$sampled(o_regf_error_type), $sampled(o_rx_mode)));
	a_crc: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		(o_rx_en && o_rx_mode == RX_CRC_CHECK && i_rx_mode_done && i_rx_error) |->
		o_regf_error_type == ERR_CRC)
		else report_error($sformatf("CHECK FAILED o_regf_error_type got %h expected %h",
			$sampled(o_regf_error_type), ERR_CRC));
	a_short: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		(ack_seen && i_regf_wr_rd_bit && i_regf_short_read && o_rx_en &&
		o_rx_mode == RX_PREAMBLE && i_rx_mode_done && !i_rx_pre && !i_frmcnt_last) |->
		o_regf_error_type == ERR_SHORT_READ)
		else report_error($sformatf("CHECK FAILED o_regf_error_type got %h expected %h",
			$sampled(o_regf_error_type), ERR_SHORT_READ));
	a_restart: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		(o_tx_en && o_tx_mode == TX_RESTART) |->
		(o_sclstall_no_of_cycles == RESTART_CYC && o_sclstall_en == !i_tx_mode_done))
		else report_error($sformatf(
			"CHECK FAILED restart o_sclstall_no_of_cycles %h o_sclstall_en %h",
			$sampled(o_sclstall_no_of_cycles), $sampled(o_sclstall_en)));
	a_exit: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		(o_tx_en && o_tx_mode == TX_EXIT) |->
		(o_sclstall_no_of_cycles == EXIT_CYC && o_sclstall_en == !i_tx_mode_done))
		else report_error($sformatf(
			"CHECK FAILED exit o_sclstall_no_of_cycles %h o_sclstall_en %h",
			$sampled(o_sclstall_no_of_cycles), $sampled(o_sclstall_en)));
	a_end_kind: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		(o_tx_en && (o_tx_mode == TX_RESTART || o_tx_mode == TX_EXIT)) |->
		o_tx_mode == (i_regf_toc ? TX_EXIT : TX_RESTART))
		else report_error($sformatf("CHECK FAILED end pattern o_tx_mode %h, toc %h",
			$sampled(o_tx_mode), $sampled(i_regf_toc)));
	a_engine_done: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		o_engine_done == (o_tx_en && o_tx_mode == TX_EXIT && i_tx_mode_done))
		else report_error($sformatf("CHECK FAILED o_engine_done got %h, o_tx_mode %h done %h",
			$sampled(o_engine_done), $sampled(o_tx_mode), $sampled(i_tx_mode_done)));

	// one frame from enable to its restart or exit pattern
	task automatic run_frame(input string name, input logic rd, input logic [4:0] dev,
		input logic toc, input logic [7:0] n, input logic nack_in, input logic short_in,
		input logic crc_in, input int exp_strobes);
		int errs_before;
		int test_no;
		begin
			errs_before = err_cnt;
			test_no = pass_tests + fail_tests + 1;
			@(negedge i_sys_clk);
			i_regf_wr_rd_bit = rd;
			i_regf_dev_index = dev;
			i_regf_toc = toc;
			nbytes = n;
			nack = nack_in;
			short_end = short_in;
			crc_err = crc_in;
			clr_cnt = 1'b1;
			@(negedge i_sys_clk);
			clr_cnt = 1'b0;
			i_engine_en = 1'b1;  // single cycle request
			started = 1'b1;
			@(negedge i_sys_clk);
			i_engine_en = 1'b0;
			while (frame_ends == 0)
				@(negedge i_sys_clk);
			@(negedge i_sys_clk);  // back in idle
			assert (strobe_cnt == exp_strobes)
				else report_error($sformatf(
					"CHECK FAILED strobe count got %h expected %h",
					strobe_cnt, exp_strobes));
			assert (done_cnt == (toc ? 1 : 0))
				else report_error($sformatf(
					"CHECK FAILED o_engine_done pulses got %h expected %h",
					done_cnt, toc));
			if (err_cnt == errs_before)
				pass_tests++;
			else
				fail_tests++;
			$display("test %0d %s: %s", test_no, name, (err_cnt == errs_before) ? "ok" : "FAILED");
		end
	endtask

	initial
	begin
		i_sys_rst = 1'b0;
		i_engine_en = 1'b0;
		i_regf_toc = 1'b0;
		i_regf_short_read = 1'b1;  // early end is an error
		i_regf_wr_rd_bit = 1'b0;
		i_regf_dev_index = 5'd0;
		nbytes = 8'd0;
		nack = 1'b0;
		short_end = 1'b0;
		crc_err = 1'b0;
		started = 1'b0;
		clr_cnt = 1'b1;
		err_cnt = 0;
		pass_tests = 0;
		fail_tests = 0;
		cycle_cnt = 0;
		repeat (16) @(negedge i_sys_clk);
		i_sys_rst = 1'b1;
		repeat (4) @(negedge i_sys_clk);  // idle outputs checked here
		run_frame("write 3 bytes, pad, restart", 1'b0, 5'd5, 1'b0, 8'd3, 1'b0, 1'b0, 1'b0, 4);
		run_frame("read 4 bytes, exit", 1'b1, 5'd3, 1'b1, 8'd4, 1'b0, 1'b0, 1'b0, 4);
		run_frame("write nack, restart", 1'b0, 5'd20, 1'b0, 8'd2, 1'b1, 1'b0, 1'b0, 0);
		run_frame("read crc error, exit", 1'b1, 5'd9, 1'b1, 8'd2, 1'b0, 1'b0, 1'b1, 2);
		run_frame("read short end, restart", 1'b1, 5'd1, 1'b0, 8'd4, 1'b0, 1'b1, 1'b0, 2);
		run_frame("write 2 bytes, exit", 1'b0, 5'd31, 1'b1, 8'd2, 1'b0, 1'b0, 1'b0, 2);
		$display("%0d tests, %0d ok, %0d failed, %0d check errors",
			pass_tests + fail_tests, pass_tests, fail_tests, err_cnt);
		if (err_cnt == 0 && fail_tests == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
src/i3c_ddr_pkg.sv
src/ddr_frame_seq.sv
src/ddr_lane_ctrl.sv
src/ddr_regf_ptr.sv
src/ddr_engine_top.sv
sim/ddr_bus_model.sv
sim/tb_ddr_engine.sv
